// File: logic/csr_pkg.sv
package csr_pkg;

    typedef logic [13:0] csr_addr_t;

    // CSR numbers
    localparam csr_addr_t CSR_CRMD      = 14'h000;
    localparam csr_addr_t CSR_PRMD      = 14'h001;
    localparam csr_addr_t CSR_ECFG      = 14'h004;
    localparam csr_addr_t CSR_ESTAT     = 14'h005;
    localparam csr_addr_t CSR_ERA       = 14'h006;
    localparam csr_addr_t CSR_BADV      = 14'h007;
    localparam csr_addr_t CSR_EENTRY    = 14'h00c;
    localparam csr_addr_t CSR_SAVE_BASE = 14'h030;
    localparam csr_addr_t CSR_TID       = 14'h040;
    localparam csr_addr_t CSR_TCFG      = 14'h041;
    localparam csr_addr_t CSR_TVAL      = 14'h042;
    localparam csr_addr_t CSR_TICLR     = 14'h044;
    localparam csr_addr_t CSR_TIMER_L   = 14'h060;
    localparam csr_addr_t CSR_TIMER_H   = 14'h061;

    // Size of the SAVE window in the view
    localparam int N_SAVE_MAX = 16;

    // Single-bit field positions
    localparam int CRMD_IE       = 2;
    localparam int PRMD_PIE      = 2;
    localparam int TCFG_EN       = 0;
    localparam int TCFG_PERIODIC = 1;
    localparam int TICLR_CLR     = 0;

    // Software-writable bits
    localparam logic [31:0] CRMD_WMASK   = 32'h0000_01ff;
    localparam logic [31:0] PRMD_WMASK   = 32'h0000_0007;
    localparam logic [31:0] ECFG_WMASK   = 32'h0000_1bff;
    localparam logic [31:0] EENTRY_WMASK = 32'hffff_ffc0;

    // DA set, everything else off
    localparam logic [31:0] CRMD_RESET = 32'h0000_0008;

    typedef struct packed {
        logic        wen;
        csr_addr_t   waddr;
        logic [31:0] wdata;
    } csr_wr_t;

    // From execute
    typedef struct packed {
        logic        is_etrn;
        logic        in_excp;
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
        logic [31:0] era;
        logic        use_badv;
        logic [31:0] badv;
    } csr_excp_bus_t;

    // Architectural values seen by the read ports
    typedef struct packed {
        logic [31:0]                 crmd;
        logic [31:0]                 prmd;
        logic [31:0]                 ecfg;
        logic [31:0]                 estat;
        logic [31:0]                 era;
        logic [31:0]                 badv;
        logic [31:0]                 eentry;
        logic [31:0]                 tid;
        logic [31:0]                 tcfg;
        logic [31:0]                 tval;
        logic [N_SAVE_MAX-1:0][31:0] save;
        logic [63:0]                 timer;
    } csr_view_t;

endpackage

// File: logic/csr_read_port.sv
`timescale 1ns/1ps

module csr_read_port #(
    parameter int N_SAVE = 4
) (
    input  csr_pkg::csr_addr_t raddr,
    input  csr_pkg::csr_view_t view,
    output logic [31:0]        rdata
);
    logic [13:0] save_off;
    logic        save_hit;

    assign save_off = raddr - csr_pkg::CSR_SAVE_BASE;
    assign save_hit = (raddr >= csr_pkg::CSR_SAVE_BASE) && (save_off < 14'(N_SAVE));

    always_comb
    begin
        rdata = 32'h0;
        case (raddr)
            csr_pkg::CSR_CRMD:    rdata = view.crmd;
            csr_pkg::CSR_PRMD:    rdata = view.prmd;
            csr_pkg::CSR_ECFG:    rdata = view.ecfg;
            csr_pkg::CSR_ESTAT:   rdata = view.estat;
            csr_pkg::CSR_ERA:     rdata = view.era;
            csr_pkg::CSR_BADV:    rdata = view.badv;
            csr_pkg::CSR_EENTRY:  rdata = view.eentry;
            csr_pkg::CSR_TID:     rdata = view.tid;
            csr_pkg::CSR_TCFG:    rdata = view.tcfg;
            csr_pkg::CSR_TVAL:    rdata = view.tval;
            csr_pkg::CSR_TIMER_L: rdata = view.timer[31:0];
            csr_pkg::CSR_TIMER_H: rdata = view.timer[63:32];
            default:
            begin
                // Unimplemented SAVE words stay 0
                if (save_hit)
                begin
                    rdata = view.save[save_off[3:0]];
                end
            end
        endcase
    end

endmodule

// File: logic/csr_timer.sv
`timescale 1ns/1ps

module csr_timer (
    input  logic             clk,
    input  logic             rst,
    input  csr_pkg::csr_wr_t wr,
    output logic [31:0]      tcfg,
    output logic [31:0]      tval,
    output logic [63:0]      timer,
    output logic             ti_pending
);
    logic        tcfg_we;
    logic        ticlr_we;
    logic        timer_en;
    logic        expire;
    logic [31:0] load_val;

    assign tcfg_we  = wr.wen && (wr.waddr == csr_pkg::CSR_TCFG);
    assign ticlr_we = wr.wen && (wr.waddr == csr_pkg::CSR_TICLR)
                      && wr.wdata[csr_pkg::TICLR_CLR];

    // Enabled and already counted down to zero
    assign expire   = timer_en && (tval == 32'h0);
    assign load_val = {tcfg[31:2], 2'b00};

    always_ff @(posedge clk)
    begin
        if (rst)
            tcfg <= 32'h0;
        else if (tcfg_we)
            tcfg <= wr.wdata;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            timer_en <= 1'b0;
        else if (tcfg_we)
            timer_en <= wr.wdata[csr_pkg::TCFG_EN];
        else if (expire)
            timer_en <= tcfg[csr_pkg::TCFG_PERIODIC];
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            tval <= 32'h0;
        end
        else if (tcfg_we)
        begin
            tval <= {wr.wdata[31:2], 2'b00};
        end
        else if (timer_en)
        begin
            if (tval != 32'h0)
                tval <= tval - 32'h1;
            else if (tcfg[csr_pkg::TCFG_PERIODIC])
                tval <= load_val;
        end
    end

    // Expiry beats a same-cycle TICLR
    always_ff @(posedge clk)
    begin
        if (rst)
            ti_pending <= 1'b0;
        else if (expire)
            ti_pending <= 1'b1;
        else if (ticlr_we)
            ti_pending <= 1'b0;
    end

    // Stable counter
    always_ff @(posedge clk)
    begin
        if (rst)
            timer <= 64'h0;
        else
            timer <= timer + 64'h1;
    end

    a_tval_bound: assert property (@(posedge clk) disable iff (rst)
        timer_en |-> (tval <= load_val))
        else $error("TVAL above current load value");

endmodule

// File: logic/csr_excp_regs.sv
`timescale 1ns/1ps

module csr_excp_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  csr_pkg::csr_wr_t       wr,
    input  csr_pkg::csr_excp_bus_t excp,
    input  logic [7:0]             intrpt,
    input  logic                   ti_pending,
    output logic [31:0]            crmd,
    output logic [31:0]            prmd,
    output logic [31:0]            ecfg,
    output logic [31:0]            estat,
    output logic [31:0]            era,
    output logic [31:0]            badv,
    output logic [31:0]            eentry,
    output logic                   excp_jump,
    output logic [31:0]            excp_pc,
    output logic                   jump_excp_fail,
    output logic                   have_intrpt
);
    logic       crmd_we;
    logic       prmd_we;
    logic       ecfg_we;
    logic       estat_we;
    logic       era_we;
    logic       badv_we;
    logic       eentry_we;
    logic       excp_take;
    logic [1:0] is_sw;
    logic [7:0] is_hw;
    logic [5:0] ecode;
    logic [8:0] esubcode;

    assign crmd_we   = wr.wen && (wr.waddr == csr_pkg::CSR_CRMD);
    assign prmd_we   = wr.wen && (wr.waddr == csr_pkg::CSR_PRMD);
    assign ecfg_we   = wr.wen && (wr.waddr == csr_pkg::CSR_ECFG);
    assign estat_we  = wr.wen && (wr.waddr == csr_pkg::CSR_ESTAT);
    assign era_we    = wr.wen && (wr.waddr == csr_pkg::CSR_ERA);
    assign badv_we   = wr.wen && (wr.waddr == csr_pkg::CSR_BADV);
    assign eentry_we = wr.wen && (wr.waddr == csr_pkg::CSR_EENTRY);

    // Entry is dropped when a CSR write collides with it
    assign excp_take = excp.in_excp && !wr.wen;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            crmd <= csr_pkg::CRMD_RESET;
        end
        else if (crmd_we)
        begin
            crmd <= wr.wdata & csr_pkg::CRMD_WMASK;
        end
        else if (excp_take)
        begin
            crmd[1:0]              <= 2'b00;
            crmd[csr_pkg::CRMD_IE] <= 1'b0;
        end
        else if (excp.is_etrn)
        begin
            crmd[1:0]              <= prmd[1:0];
            crmd[csr_pkg::CRMD_IE] <= prmd[csr_pkg::PRMD_PIE];
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            prmd <= 32'h0;
        else if (prmd_we)
            prmd <= wr.wdata & csr_pkg::PRMD_WMASK;
        else if (excp_take)
            prmd <= {29'h0, crmd[csr_pkg::CRMD_IE], crmd[1:0]};
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            ecfg <= 32'h0;
        else if (ecfg_we)
            ecfg <= wr.wdata & csr_pkg::ECFG_WMASK;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            is_sw    <= 2'b00;
            ecode    <= 6'h0;
            esubcode <= 9'h0;
        end
        else if (estat_we)
        begin
            is_sw <= wr.wdata[1:0];
        end
        else if (excp_take)
        begin
            ecode    <= excp.ecode;
            esubcode <= excp.esubcode;
        end
    end

    // Hardware lines land one cycle late
    always_ff @(posedge clk)
    begin
        if (rst)
            is_hw <= 8'h0;
        else
            is_hw <= intrpt;
    end

    // Timer bit 11 is the live pending level
    assign estat = {1'b0, esubcode, ecode, 4'h0, ti_pending, 1'b0, is_hw, is_sw};

    always_ff @(posedge clk)
    begin
        if (rst)
            era <= 32'h0;
        else if (era_we)
            era <= wr.wdata;
        else if (excp_take)
            era <= excp.era;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            badv <= 32'h0;
        else if (badv_we)
            badv <= wr.wdata;
        else if (excp_take && excp.use_badv)
            badv <= excp.badv;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            eentry <= 32'h0;
        else if (eentry_we)
            eentry <= wr.wdata & csr_pkg::EENTRY_WMASK;
    end

    assign jump_excp_fail = wr.wen && excp.in_excp;
    assign excp_jump      = (excp.in_excp || excp.is_etrn) && !jump_excp_fail;

    // ERTN sees an ERA write from the same cycle
    assign excp_pc = excp.in_excp ? eentry :
                     era_we       ? wr.wdata : era;

    assign have_intrpt = crmd[csr_pkg::CRMD_IE] && |(ecfg[12:0] & estat[12:0]);

    a_excp_etrn_excl: assert property (@(posedge clk) disable iff (rst)
        !(excp.in_excp && excp.is_etrn))
        else $error("Exception and return in the same cycle");

endmodule

// File: logic/csr_scratch.sv
`timescale 1ns/1ps

module csr_scratch #(
    parameter int N_SAVE = 4
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  csr_pkg::csr_wr_t                     wr,
    output logic [csr_pkg::N_SAVE_MAX-1:0][31:0] save,
    output logic [31:0]                          tid
);
    logic [N_SAVE-1:0][31:0] save_q;
    logic [13:0]             save_off;
    logic                    save_win;
    logic                    save_we;
    logic                    tid_we;

    assign save_off = wr.waddr - csr_pkg::CSR_SAVE_BASE;
    assign save_win = (wr.waddr >= csr_pkg::CSR_SAVE_BASE)
                      && (save_off < 14'(csr_pkg::N_SAVE_MAX));
    assign save_we  = wr.wen && save_win && (save_off < 14'(N_SAVE));
    assign tid_we   = wr.wen && (wr.waddr == csr_pkg::CSR_TID);

    always_ff @(posedge clk)
    begin
        if (rst)
            save_q <= '0;
        else if (save_we)
            save_q[save_off[3:0]] <= wr.wdata;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            tid <= 32'h0;
        else if (tid_we)
            tid <= wr.wdata;
    end

    // Words above N_SAVE read as zero
    always_comb
    begin
        save = '0;
        for (int i = 0; i < N_SAVE; i++)
            save[i] = save_q[i];
    end

    a_save_range: assert property (@(posedge clk) disable iff (rst)
        (wr.wen && ((wr.waddr < csr_pkg::CSR_SAVE_BASE)
                    || (wr.waddr >= csr_pkg::CSR_SAVE_BASE + 14'(N_SAVE))))
        |=> $stable(save))
        else $error("Write outside SAVE0..N_SAVE-1 changed the bank");

endmodule

// File: logic/csr_unit.sv
`timescale 1ns/1ps

module csr_unit #(
    parameter int N_SAVE = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  csr_pkg::csr_addr_t     raddr1,
    output logic [31:0]            rdata1,
    input  csr_pkg::csr_addr_t     raddr2,
    output logic [31:0]            rdata2,
    input  csr_pkg::csr_wr_t       wr,
    input  csr_pkg::csr_excp_bus_t excp,
    input  logic [7:0]             intrpt,
    output logic                   excp_jump,
    output logic [31:0]            excp_pc,
    output logic                   jump_excp_fail,
    output logic                   have_intrpt
);
    logic [31:0]                          crmd;
    logic [31:0]                          prmd;
    logic [31:0]                          ecfg;
    logic [31:0]                          estat;
    logic [31:0]                          era;
    logic [31:0]                          badv;
    logic [31:0]                          eentry;
    logic [31:0]                          tid;
    logic [31:0]                          tcfg;
    logic [31:0]                          tval;
    logic [63:0]                          timer;
    logic [csr_pkg::N_SAVE_MAX-1:0][31:0] save;
    logic                                 ti_pending;
    csr_pkg::csr_view_t                   view;

    csr_timer u_timer (
        .clk        (clk),
        .rst        (rst),
        .wr         (wr),
        .tcfg       (tcfg),
        .tval       (tval),
        .timer      (timer),
        .ti_pending (ti_pending)
    );

    csr_excp_regs u_excp (
        .clk            (clk),
        .rst            (rst),
        .wr             (wr),
        .excp           (excp),
        .intrpt         (intrpt),
        .ti_pending     (ti_pending),
        .crmd           (crmd),
        .prmd           (prmd),
        .ecfg           (ecfg),
        .estat          (estat),
        .era            (era),
        .badv           (badv),
        .eentry         (eentry),
        .excp_jump      (excp_jump),
        .excp_pc        (excp_pc),
        .jump_excp_fail (jump_excp_fail),
        .have_intrpt    (have_intrpt)
    );

    csr_scratch #(.N_SAVE(N_SAVE)) u_scratch (
        .clk  (clk),
        .rst  (rst),
        .wr   (wr),
        .save (save),
        .tid  (tid)
    );

    assign view = '{crmd: crmd, prmd: prmd, ecfg: ecfg, estat: estat, era: era,
                    badv: badv, eentry: eentry, tid: tid, tcfg: tcfg, tval: tval,
                    save: save, timer: timer};

    // One port per decode slot
    csr_read_port #(.N_SAVE(N_SAVE)) u_rd1 (
        .raddr (raddr1),
        .view  (view),
        .rdata (rdata1)
    );

    csr_read_port #(.N_SAVE(N_SAVE)) u_rd2 (
        .raddr (raddr2),
        .view  (view),
        .rdata (rdata2)
    );

endmodule

// File: tb/csr_unit_tb.sv
`timescale 1ns/1ps

module csr_unit_tb;

    localparam logic [3:0] CK_RD   = 4'b0001;
    localparam logic [3:0] CK_INT  = 4'b0010;
    localparam logic [3:0] CK_MARK = 4'b0100;
    localparam logic [3:0] CK_DIFF = 4'b1000;

    typedef struct packed {
        int                     test;
        csr_pkg::csr_wr_t       wr;
        csr_pkg::csr_excp_bus_t excp;
        logic [7:0]             intrpt;
        csr_pkg::csr_addr_t     ra1;
        logic [31:0]            e1;
        csr_pkg::csr_addr_t     ra2;
        logic [31:0]            e2;
        logic                   ejump;
        logic [31:0]            epc;
        logic                   efail;
        logic                   eint;
        logic [3:0]             chk;
        int                     wait_cyc;
    } step_t;

    logic                   clk;
    logic                   rst;
    csr_pkg::csr_addr_t     raddr1;
    csr_pkg::csr_addr_t     raddr2;
    logic [31:0]            rdata1;
    logic [31:0]            rdata2;
    csr_pkg::csr_wr_t       wr;
    csr_pkg::csr_excp_bus_t excp;
    logic [7:0]             intrpt;
    logic                   excp_jump;
    logic [31:0]            excp_pc;
    logic                   jump_excp_fail;
    logic                   have_intrpt;

    step_t       steps[$];
    step_t       nxt;
    string       test_name [1:6];
    logic [31:0] rnd [0:4];
    logic [31:0] mark_val;
    int          mark_cyc;
    int          cycles = 0;
    int          limit = 0;
    int          cur_step;
    int          checks = 0;
    int          errors = 0;
    int          test_checks = 0;
    int          test_errors = 0;

    csr_unit #(.N_SAVE(4)) u_dut (
        .clk            (clk),
        .rst            (rst),
        .raddr1         (raddr1),
        .rdata1         (rdata1),
        .raddr2         (raddr2),
        .rdata2         (rdata2),
        .wr             (wr),
        .excp           (excp),
        .intrpt         (intrpt),
        .excp_jump      (excp_jump),
        .excp_pc        (excp_pc),
        .jump_excp_fail (jump_excp_fail),
        .have_intrpt    (have_intrpt)
    );

    always #4 clk = ~clk;

    // Run limit guard
    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit)
        begin
            $display("Timeout: run went past %0d cycles without finishing", limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic check_data(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        test_checks++;
        if (got !== exp)
        begin
            errors++;
            test_errors++;
            $display("FAILED step %0d %s: expected %h, got %h", cur_step, name, exp, got);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        test_checks++;
        if (got !== exp)
        begin
            errors++;
            test_errors++;
            $display("FAILED step %0d %s: expected %h, got %h", cur_step, name, exp, got);
        end
    endtask

    task automatic add_step(input logic wen, input csr_pkg::csr_addr_t wa, input logic [31:0] wd,
                            input csr_pkg::csr_addr_t a1, input logic [31:0] e1,
                            input csr_pkg::csr_addr_t a2, input logic [31:0] e2,
                            input logic eint, input logic [3:0] chk, input int w);
        step_t s;
        s = nxt;
        s.wr.wen = wen;
        s.wr.waddr = wa;
        s.wr.wdata = wd;
        s.ra1 = a1;
        s.e1 = e1;
        s.ra2 = a2;
        s.e2 = e2;
        s.eint = eint;
        s.chk = chk;
        s.wait_cyc = w;
        steps.push_back(s);
        limit += w + 1;
        nxt.excp = '0;
        nxt.ejump = 1'b0;
        nxt.epc = 32'h0;
        nxt.efail = 1'b0;
    endtask

    task automatic add_read(input csr_pkg::csr_addr_t a1, input logic [31:0] e1,
                            input csr_pkg::csr_addr_t a2, input logic [31:0] e2,
                            input logic eint, input int w);
        add_step(1'b0, csr_pkg::CSR_CRMD, 32'h0, a1, e1, a2, e2, eint, CK_RD | CK_INT, w);
    endtask

    task automatic add_write(input csr_pkg::csr_addr_t a, input logic [31:0] d, input int w);
        add_step(1'b1, a, d, csr_pkg::CSR_CRMD, 32'h0, csr_pkg::CSR_CRMD, 32'h0, 1'b0, 4'b0, w);
    endtask

    task automatic add_read_write(input csr_pkg::csr_addr_t a, input logic [31:0] d,
                                  input csr_pkg::csr_addr_t a1, input logic [31:0] e1,
                                  input csr_pkg::csr_addr_t a2, input logic [31:0] e2,
                                  input logic eint, input int w);
        add_step(1'b1, a, d, a1, e1, a2, e2, eint, CK_RD | CK_INT, w);
    endtask

    // Exception bus and redirect expectations for the next step only
    task automatic set_excp(input logic in_excp, input logic is_etrn, input logic [5:0] ecode,
                            input logic [8:0] esub, input logic [31:0] era, input logic use_badv,
                            input logic [31:0] badv, input logic ejump, input logic [31:0] epc,
                            input logic efail);
        nxt.excp.in_excp = in_excp;
        nxt.excp.is_etrn = is_etrn;
        nxt.excp.ecode = ecode;
        nxt.excp.esubcode = esub;
        nxt.excp.era = era;
        nxt.excp.use_badv = use_badv;
        nxt.excp.badv = badv;
        nxt.ejump = ejump;
        nxt.epc = epc;
        nxt.efail = efail;
    endtask

    task automatic build_table();
        nxt = '0;
        for (int i = 0; i < 5; i++)
            rnd[i] = $urandom();
        test_name[1] = "reset values";
        test_name[2] = "write and read-back";
        test_name[3] = "exception entry and return";
        test_name[4] = "hardware interrupts";
        test_name[5] = "timer";
        test_name[6] = "stable counter";

        nxt.test = 1;
        add_read(csr_pkg::CSR_CRMD, 32'h8, csr_pkg::CSR_PRMD, 32'h0, 1'b0, 0);
        add_read(csr_pkg::CSR_ECFG, 32'h0, csr_pkg::CSR_ESTAT, 32'h0, 1'b0, 0);
        add_read(csr_pkg::CSR_ERA, 32'h0, csr_pkg::CSR_BADV, 32'h0, 1'b0, 0);
        add_read(csr_pkg::CSR_EENTRY, 32'h0, csr_pkg::CSR_TID, 32'h0, 1'b0, 0);
        add_read(csr_pkg::CSR_TCFG, 32'h0, csr_pkg::CSR_TVAL, 32'h0, 1'b0, 0);
        add_read(14'h030, 32'h0, 14'h033, 32'h0, 1'b0, 0);
        add_read(csr_pkg::CSR_TIMER_H, 32'h0, 14'h031, 32'h0, 1'b0, 0);

        nxt.test = 2;
        for (int i = 0; i < 4; i++)
            add_write(csr_pkg::CSR_SAVE_BASE + 14'(i), rnd[i], 0);
        add_write(csr_pkg::CSR_TID, rnd[4], 0);
        add_write(14'h034, 32'hffff_ffff, 0);
        add_write(csr_pkg::CSR_EENTRY, 32'h1234_5678, 0);
        add_write(csr_pkg::CSR_ECFG, 32'hffff_ffff, 0);
        add_read(14'h030, rnd[0], 14'h031, rnd[1], 1'b0, 0);
        add_read(14'h032, rnd[2], 14'h033, rnd[3], 1'b0, 0);
        add_read(csr_pkg::CSR_TID, rnd[4], 14'h034, 32'h0, 1'b0, 0);
        add_read(csr_pkg::CSR_EENTRY, 32'h1234_5640, csr_pkg::CSR_ECFG, 32'h1bff, 1'b0, 0);
        add_read(14'h3fff, 32'h0, 14'h050, 32'h0, 1'b0, 0);
        add_write(csr_pkg::CSR_ECFG, 32'h0, 0);

        // DA with PLV 3 and IE set
        nxt.test = 3;
        add_write(csr_pkg::CSR_CRMD, 32'hf, 0);
        set_excp(1'b1, 1'b0, 6'h08, 9'h001, 32'h1c00_0100, 1'b1, 32'hdead_beef,
                 1'b1, 32'h1234_5640, 1'b0);
        add_read(csr_pkg::CSR_CRMD, 32'hf, csr_pkg::CSR_EENTRY, 32'h1234_5640, 1'b0, 0);
        add_read(csr_pkg::CSR_CRMD, 32'h8, csr_pkg::CSR_PRMD, 32'h7, 1'b0, 0);
        // Esubcode 1 at bit 22, Ecode 8 at bit 16
        add_read(csr_pkg::CSR_ESTAT, 32'h0048_0000, csr_pkg::CSR_ERA, 32'h1c00_0100, 1'b0, 0);
        add_read(csr_pkg::CSR_BADV, 32'hdead_beef, csr_pkg::CSR_CRMD, 32'h8, 1'b0, 0);
        set_excp(1'b0, 1'b1, 6'h0, 9'h0, 32'h0, 1'b0, 32'h0, 1'b1, 32'h1c00_0100, 1'b0);
        add_read(csr_pkg::CSR_ERA, 32'h1c00_0100, csr_pkg::CSR_PRMD, 32'h7, 1'b0, 0);
        add_read(csr_pkg::CSR_CRMD, 32'hf, csr_pkg::CSR_PRMD, 32'h7, 1'b0, 0);
        set_excp(1'b0, 1'b1, 6'h0, 9'h0, 32'h0, 1'b0, 32'h0, 1'b1, 32'h1c00_0200, 1'b0);
        add_write(csr_pkg::CSR_ERA, 32'h1c00_0200, 0);
        set_excp(1'b1, 1'b0, 6'h3f, 9'h1ff, 32'h0000_0abc, 1'b1, 32'h1111_1111,
                 1'b0, 32'h0, 1'b1);
        add_write(14'h030, 32'h5555_aaaa, 0);
        add_read(csr_pkg::CSR_CRMD, 32'hf, csr_pkg::CSR_PRMD, 32'h7, 1'b0, 0);
        add_read(csr_pkg::CSR_ESTAT, 32'h0048_0000, csr_pkg::CSR_ERA, 32'h1c00_0200, 1'b0, 0);
        add_read(csr_pkg::CSR_BADV, 32'hdead_beef, 14'h030, 32'h5555_aaaa, 1'b0, 0);

        // Lines 0xa5 land in ESTAT[9:2] as 0x294
        nxt.test = 4;
        nxt.intrpt = 8'ha5;
        add_read(csr_pkg::CSR_ESTAT, 32'h0048_0000, csr_pkg::CSR_ECFG, 32'h0, 1'b0, 0);
        add_read(csr_pkg::CSR_ESTAT, 32'h0048_0294, csr_pkg::CSR_CRMD, 32'hf, 1'b0, 0);
        add_write(csr_pkg::CSR_ECFG, 32'h4, 0);
        add_read(csr_pkg::CSR_ECFG, 32'h4, csr_pkg::CSR_ESTAT, 32'h0048_0294, 1'b1, 0);
        add_write(csr_pkg::CSR_CRMD, 32'hb, 0);
        add_read(csr_pkg::CSR_CRMD, 32'hb, csr_pkg::CSR_ECFG, 32'h4, 1'b0, 0);
        add_write(csr_pkg::CSR_ECFG, 32'h8, 0);
        add_write(csr_pkg::CSR_CRMD, 32'hf, 0);
        add_read(csr_pkg::CSR_CRMD, 32'hf, csr_pkg::CSR_ECFG, 32'h8, 1'b0, 0);
        add_write(csr_pkg::CSR_ESTAT, 32'hffff_ffff, 0);
        add_write(csr_pkg::CSR_ECFG, 32'h1, 0);
        add_read(csr_pkg::CSR_ESTAT, 32'h0048_0297, csr_pkg::CSR_ECFG, 32'h1, 1'b1, 0);
        add_write(csr_pkg::CSR_ESTAT, 32'h0, 0);
        nxt.intrpt = 8'h00;
        add_write(csr_pkg::CSR_ECFG, 32'h0, 0);
        add_read(csr_pkg::CSR_ESTAT, 32'h0048_0000, csr_pkg::CSR_ECFG, 32'h0, 1'b0, 0);

        // One-shot load 12, then periodic load 8 with a 9-cycle period
        nxt.test = 5;
        add_write(csr_pkg::CSR_ECFG, 32'h800, 0);
        add_write(csr_pkg::CSR_TCFG, 32'hd, 12);
        add_read(csr_pkg::CSR_ESTAT, 32'h0048_0000, csr_pkg::CSR_TVAL, 32'h0, 1'b0, 0);
        add_read(csr_pkg::CSR_ESTAT, 32'h0048_0800, csr_pkg::CSR_TCFG, 32'hd, 1'b1, 0);
        add_write(csr_pkg::CSR_TICLR, 32'h1, 0);
        add_read(csr_pkg::CSR_ESTAT, 32'h0048_0000, csr_pkg::CSR_TVAL, 32'h0, 1'b0, 0);
        add_write(csr_pkg::CSR_TCFG, 32'hb, 8);
        add_read(csr_pkg::CSR_ESTAT, 32'h0048_0000, csr_pkg::CSR_TVAL, 32'h0, 1'b0, 0);
        add_read_write(csr_pkg::CSR_TICLR, 32'h1, csr_pkg::CSR_ESTAT, 32'h0048_0800,
                       csr_pkg::CSR_TVAL, 32'h8, 1'b1, 0);
        add_read(csr_pkg::CSR_ESTAT, 32'h0048_0000, csr_pkg::CSR_TVAL, 32'h7, 1'b0, 6);
        // Clear lands in the expiry cycle
        add_read_write(csr_pkg::CSR_TICLR, 32'h1, csr_pkg::CSR_ESTAT, 32'h0048_0000,
                       csr_pkg::CSR_TVAL, 32'h0, 1'b0, 0);
        add_read(csr_pkg::CSR_ESTAT, 32'h0048_0800, csr_pkg::CSR_TVAL, 32'h8, 1'b1, 0);
        add_write(csr_pkg::CSR_TCFG, 32'h0, 0);
        add_write(csr_pkg::CSR_TICLR, 32'h1, 0);
        add_read(csr_pkg::CSR_ESTAT, 32'h0048_0000, csr_pkg::CSR_TCFG, 32'h0, 1'b0, 0);

        nxt.test = 6;
        add_step(1'b0, csr_pkg::CSR_CRMD, 32'h0, csr_pkg::CSR_TIMER_L, 32'h0,
                 csr_pkg::CSR_TIMER_H, 32'h0, 1'b0, CK_RD | CK_INT | CK_MARK, 5);
        add_step(1'b0, csr_pkg::CSR_CRMD, 32'h0, csr_pkg::CSR_TIMER_L, 32'h0,
                 csr_pkg::CSR_TIMER_H, 32'h0, 1'b0, CK_RD | CK_INT | CK_DIFF, 0);
        limit += 100;
    endtask

    task automatic drive(input step_t s);
        wr = s.wr;
        excp = s.excp;
        intrpt = s.intrpt;
        raddr1 = s.ra1;
        raddr2 = s.ra2;
    endtask

    task automatic check_step(input step_t s);
        logic [31:0] exp1;
        exp1 = s.e1;
        if ((s.chk & CK_DIFF) != 0)
            exp1 = mark_val + 32'(cycles - mark_cyc);
        if ((s.chk & CK_MARK) != 0)
        begin
            mark_val = rdata1;
            mark_cyc = cycles;
        end
        else if ((s.chk & CK_RD) != 0)
        begin
            check_data("rdata1", rdata1, exp1);
        end
        if ((s.chk & CK_RD) != 0)
            check_data("rdata2", rdata2, s.e2);
        check_bit("excp_jump", excp_jump, s.ejump);
        check_bit("jump_excp_fail", jump_excp_fail, s.efail);
        if (s.ejump)
            check_data("excp_pc", excp_pc, s.epc);
        if ((s.chk & CK_INT) != 0)
            check_bit("have_intrpt", have_intrpt, s.eint);
    endtask

    initial
    begin
        void'($urandom(32'h3a85_d131));
        clk = 1'b0;
        rst = 1'b1;
        wr = '0;
        excp = '0;
        intrpt = 8'h0;
        raddr1 = '0;
        raddr2 = '0;
        build_table();
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < steps.size(); i++)
        begin
            cur_step = i;
            @(posedge clk);
            #1;
            drive(steps[i]);
            // Outputs settled well before the next edge
            #5;
            check_step(steps[i]);
            repeat (steps[i].wait_cyc)
            begin
                @(posedge clk);
                #1;
                wr.wen = 1'b0;
                excp = '0;
            end
            if (i == steps.size() - 1 || steps[i + 1].test != steps[i].test)
            begin
                $display("test %0d %s: %0d checks, %0d errors", steps[i].test,
                         test_name[steps[i].test], test_checks, test_errors);
                test_checks = 0;
                test_errors = 0;
            end
        end
        $display("6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: csr_unit.f
logic/csr_pkg.sv
logic/csr_read_port.sv
logic/csr_timer.sv
logic/csr_excp_regs.sv
logic/csr_scratch.sv
logic/csr_unit.sv
tb/csr_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the CSR unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f csr_unit.f --top-module csr_unit_tb -o csr_unit_sim

./obj_dir/csr_unit_sim > sim.log
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
    exit 1
fi
exit 0
